/* design/ntm_pkg.sv */
package ntm_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and limits
  //////////////////////////////////////////////////////////////////////

  // Weight and memory element width
  localparam int DATA_W = 16;

  // Accumulator width, room for N_MAX full-scale products
  localparam int ACC_W = 40;

  // Largest row count per job
  localparam int N_MAX = 256;

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic signed [DATA_W-1:0] elem_t;
  typedef logic signed [ACC_W-1:0]  acc_t;

  // Row counter, 9 bits hold 256
  typedef logic [8:0] count_t;

  //////////////////////////////////////////////////////////////////////
  // Lane structs
  //////////////////////////////////////////////////////////////////////

  // One row's work for a single column
  typedef struct packed {
    elem_t weight;
    elem_t elem;
    logic  first;  // row 0
    logic  last;   // row N-1
  } lane_op_t;

  // Column result, more status may join later
  typedef struct packed {
    acc_t sum;
  } lane_res_t;

endpackage

/* design/ntm_read_dispatch.sv */
module ntm_read_dispatch #(
  parameter int LANES = 4
) (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                START,
  input  logic                                M_IN_J_ENABLE,
  input  ntm_pkg::count_t                     SIZE_N_IN,
  input  ntm_pkg::elem_t                      W_IN,
  input  ntm_pkg::elem_t   [LANES-1:0]        M_IN,
  output ntm_pkg::lane_op_t [LANES-1:0]       ops,
  output logic                                op_valid
);

  import ntm_pkg::*;

  // Job controller states
  typedef enum logic {
    S_IDLE,
    S_RUN
  } state_t;

  state_t state;
  count_t size_q;   // requested rows
  count_t row_cnt;  // rows accepted so far
  logic   row_acc;
  logic   row_last;

  // Registered row, shared by all lanes
  elem_t              weight_q;
  elem_t [LANES-1:0]  elem_q;
  logic               first_q;
  logic               last_q;

  // Strobe counts only inside a job
  assign row_acc  = (state == S_RUN) && M_IN_J_ENABLE;
  assign row_last = (row_cnt == size_q - count_t'(1));

  //////////////////////////////////////////////////////////////////////
  // Job control and row tags
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= S_IDLE;
      size_q   <= '0;
      row_cnt  <= '0;
      op_valid <= 1'b0;
      first_q  <= 1'b0;
      last_q   <= 1'b0;
    end else begin
      op_valid <= row_acc;
      first_q  <= row_acc && (row_cnt == '0);
      last_q   <= row_acc && row_last;
      case (state)
        S_IDLE: begin
          if (START) begin
            size_q  <= SIZE_N_IN;
            row_cnt <= '0;
            state   <= S_RUN;
          end
        end
        S_RUN: begin
          if (row_acc) begin
            row_cnt <= row_cnt + count_t'(1);
            // Nth row closes the job
            if (row_last) state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // Row payload, no reset
  always_ff @(posedge CLK) begin
    if (row_acc) begin
      weight_q <= W_IN;
      elem_q   <= M_IN;
    end
  end

  // Broadcast weight, each lane gets its own column
  always_comb begin
    for (int k = 0; k < LANES; k++) begin
      ops[k] = '{weight: weight_q, elem: elem_q[k], first: first_q, last: last_q};
    end
  end

  // Row count in range at job start
  a_size_range: assert property (@(posedge CLK) disable iff (RST)
    START |-> (SIZE_N_IN >= count_t'(1)) && (SIZE_N_IN <= count_t'(N_MAX)));

  // Host waits for the running job
  a_start_idle: assert property (@(posedge CLK) disable iff (RST)
    START |-> state == S_IDLE);

endmodule

/* design/ntm_read_lane.sv */
module ntm_read_lane (
  input  logic               CLK,
  input  logic               RST,
  input  logic               op_valid,
  input  ntm_pkg::lane_op_t  op,
  output ntm_pkg::lane_res_t res,
  output logic               done
);

  import ntm_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Multiply
  //////////////////////////////////////////////////////////////////////

  // Full signed product, extended to accumulator width
  acc_t prod;
  acc_t sum_q;

  assign prod = acc_t'(op.weight) * acc_t'(op.elem);

  //////////////////////////////////////////////////////////////////////
  // Accumulate
  //////////////////////////////////////////////////////////////////////

  // First row restarts, so jobs run back to back
  always_ff @(posedge CLK) begin
    if (op_valid) begin
      if (op.first) sum_q <= prod;
      else          sum_q <= sum_q + prod;  // wraps mod 2^ACC_W
    end
  end

  // Column complete with the final sum
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      done <= 1'b0;
    end else begin
      done <= op_valid && op.last;
    end
  end

  assign res.sum = sum_q;

  // Row tags only come with a valid row
  a_tag_valid: assert property (@(posedge CLK) disable iff (RST)
    (op.first || op.last) |-> op_valid);

endmodule

/* design/ntm_read_collect.sv */
module ntm_read_collect #(
  parameter int LANES = 4
) (
  input  logic                             CLK,
  input  logic                             RST,
  input  ntm_pkg::lane_res_t [LANES-1:0]   res,
  input  logic               [LANES-1:0]   done,
  output ntm_pkg::acc_t                    R_OUT,
  output logic                             R_OUT_ENABLE,
  output logic                             READY
);

  import ntm_pkg::*;

  // Index width, kept at one bit for a single lane
  localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LANES - 1);

  // Shadow bank of column sums
  acc_t             bank [LANES];
  logic [IDX_W-1:0] idx;
  logic             busy;

  //////////////////////////////////////////////////////////////////////
  // Capture
  //////////////////////////////////////////////////////////////////////

  // All lanes finish together, lane 0 stands for all
  always_ff @(posedge CLK) begin
    if (done[0]) begin
      for (int k = 0; k < LANES; k++) begin
        bank[k] <= res[k].sum;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output burst
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy         <= 1'b0;
      idx          <= '0;
      R_OUT        <= '0;
      R_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      // Pulse after the last word leaves
      READY        <= R_OUT_ENABLE && !busy;
      R_OUT_ENABLE <= busy;
      if (done[0]) begin
        busy <= 1'b1;
        idx  <= '0;
      end else if (busy) begin
        R_OUT <= bank[idx];
        idx   <= idx + 1'b1;
        if (idx == LAST_IDX) busy <= 1'b0;
      end
    end
  end

  // Lanes must agree on completion
  a_done_agree: assert property (@(posedge CLK) disable iff (RST)
    |done |-> &done);

  // New job result only after the burst, else START came early
  a_done_idle: assert property (@(posedge CLK) disable iff (RST)
    done[0] |-> !busy);

endmodule

/* design/ntm_reading.sv */
module ntm_reading #(
  parameter int LANES = 4
) (
  input  logic                          CLK,
  input  logic                          RST,
  input  logic                          START,
  input  logic                          M_IN_J_ENABLE,
  input  ntm_pkg::count_t               SIZE_N_IN,
  input  ntm_pkg::elem_t                W_IN,
  input  ntm_pkg::elem_t [LANES-1:0]    M_IN,
  output ntm_pkg::acc_t                 R_OUT,
  output logic                          R_OUT_ENABLE,
  output logic                          READY
);

  import ntm_pkg::*;

  // r(k) = sum over j of w(j) * M(j,k)

  // Dispatcher to lanes
  lane_op_t  [LANES-1:0] ops;
  logic                  op_valid;

  // Lanes to collector
  lane_res_t [LANES-1:0] res;
  logic      [LANES-1:0] done;

  //////////////////////////////////////////////////////////////////////
  // Row intake
  //////////////////////////////////////////////////////////////////////

  ntm_read_dispatch #(
    .LANES(LANES)
  ) u_dispatch (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .M_IN_J_ENABLE(M_IN_J_ENABLE),
    .SIZE_N_IN    (SIZE_N_IN),
    .W_IN         (W_IN),
    .M_IN         (M_IN),
    .ops          (ops),
    .op_valid     (op_valid)
  );

  // One MAC lane per column
  for (genvar k = 0; k < LANES; k++) begin : g_lane
    ntm_read_lane u_lane (
      .CLK     (CLK),
      .RST     (RST),
      .op_valid(op_valid),
      .op      (ops[k]),
      .res     (res[k]),
      .done    (done[k])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // Result drain
  //////////////////////////////////////////////////////////////////////

  ntm_read_collect #(
    .LANES(LANES)
  ) u_collect (
    .CLK         (CLK),
    .RST         (RST),
    .res         (res),
    .done        (done),
    .R_OUT       (R_OUT),
    .R_OUT_ENABLE(R_OUT_ENABLE),
    .READY       (READY)
  );

endmodule

/* tests/tb_clock.sv */
module tb_clock #(
  parameter int PERIOD     = 100,
  parameter int RST_CYCLES = 2
) (
  output logic CLK,
  output logic RST
);

  // Free running clock, low at time zero
  initial begin
    CLK = 1'b0;
    forever #(PERIOD / 2) CLK = ~CLK;
  end

  // Reset over RST_CYCLES rising edges, released on a falling edge
  initial begin
    RST = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
  end

endmodule

/* tests/tb_ntm_reading.sv */
module tb_ntm_reading;

  import ntm_pkg::*;

  localparam int LANES = 4;

  logic              CLK;
  logic              RST;
  logic              START;
  logic              M_IN_J_ENABLE;
  count_t            SIZE_N_IN;
  elem_t             W_IN;
  elem_t [LANES-1:0] M_IN;
  acc_t              R_OUT;
  logic              R_OUT_ENABLE;
  logic              READY;

  // Job tables with the rows of all jobs back to back
  count_t            job_n[$];
  int                job_stray[$];
  int                row_gap[$];
  elem_t             row_w[$];
  elem_t [LANES-1:0] row_m[$];
  acc_t              exp_r[$];

  // Output log of the running job
  acc_t got[$];
  int   cyc = 0;
  int   en_cnt;
  int   rdy_cnt;
  int   first_en;
  int   last_en;
  int   ready_at;
  int   limit_cycles = 0;
  int   seed = 32'h62f2d3f2;

  tb_clock #(.PERIOD(100), .RST_CYCLES(2)) u_clock (.CLK(CLK), .RST(RST));

  ntm_reading #(.LANES(LANES)) UUT (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .M_IN_J_ENABLE(M_IN_J_ENABLE),
    .SIZE_N_IN    (SIZE_N_IN),
    .W_IN         (W_IN),
    .M_IN         (M_IN),
    .R_OUT        (R_OUT),
    .R_OUT_ENABLE (R_OUT_ENABLE),
    .READY        (READY)
  );

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_result(input int k, input acc_t actual, input acc_t expected);
    if (actual !== expected)
      abort_run($sformatf("mismatch R_OUT[%0d] got %h expected %h", k, actual, expected));
  endtask

  task automatic check_count(input string what, input count_t actual,
                             input count_t expected);
    if (actual !== expected)
      abort_run($sformatf("mismatch %s got %h expected %h", what, actual, expected));
  endtask

  // r(k) of one job with products wrapping into ACC_W bits
  function automatic acc_t column_sum(input int base, input int n, input int k);
    acc_t   s;
    elem_t  w;
    elem_t  e;
    longint p;
    s = '0;
    for (int j = 0; j < n; j++) begin
      w = row_w[base + j];
      e = row_m[base + j][k];
      p = longint'(w) * longint'(e);
      s = s + acc_t'(p);
    end
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  // Sample outputs on the falling edge and then drive the next inputs
  task automatic step_cycle(input logic start, input logic strobe, input count_t n,
                            input elem_t w, input elem_t [LANES-1:0] m);
    @(negedge CLK);
    cyc++;
    if (R_OUT_ENABLE) begin
      if (en_cnt == 0) first_en = cyc;
      last_en = cyc;
      en_cnt++;
      got.push_back(R_OUT);
    end
    if (READY) begin
      ready_at = cyc;
      rdy_cnt++;
    end
    START         = start;
    SIZE_N_IN     = n;
    M_IN_J_ENABLE = strobe;
    W_IN          = w;
    M_IN          = m;
  endtask

  task automatic idle_cycle();
    step_cycle(1'b0, 1'b0, '0, '0, '0);
  endtask

  task automatic load_stim();
    int                fd;
    int                code;
    int                n;
    int                stray;
    int                gap;
    elem_t             w;
    elem_t             e;
    elem_t [LANES-1:0] m;
    acc_t              r;
    string             line;
    fd = $fopen("tests/ntm_reading_stim.txt", "r");
    if (fd == 0) abort_run("cannot open the stim file tests/ntm_reading_stim.txt");
    // Skip the column notes at the top
    code = $fgets(line, fd);
    while (code != 0 && line.substr(0, 0) == "#")
      code = $fgets(line, fd);
    code = (code != 0) ? $sscanf(line, "%d %d", n, stray) : 0;
    while (code == 2) begin
      job_n.push_back(count_t'(n));
      job_stray.push_back(stray);
      for (int j = 0; j < n; j++) begin
        code = $fscanf(fd, "%d %h", gap, w);
        for (int k = 0; k < LANES; k++) begin
          code += $fscanf(fd, "%h", e);
          m[k] = e;
        end
        if (code != LANES + 2) abort_run("stim file has a broken row line");
        row_gap.push_back(gap);
        row_w.push_back(w);
        row_m.push_back(m);
      end
      for (int k = 0; k < LANES; k++) begin
        if ($fscanf(fd, "%h", r) != 1) abort_run("stim file has a broken expected line");
        exp_r.push_back(r);
      end
      code = $fscanf(fd, "%d %d", n, stray);
    end
    $fclose(fd);
    if (job_n.size() == 0) abort_run("stim file holds no jobs");
  endtask

  // Random job with its expected vector from the sum rule
  task automatic add_random_job();
    int                n;
    int                base;
    elem_t [LANES-1:0] m;
    base = row_w.size();
    n = 1 + int'($unsigned($random(seed)) % 20);
    job_n.push_back(count_t'(n));
    job_stray.push_back(1);
    for (int j = 0; j < n; j++) begin
      row_gap.push_back(int'($unsigned($random(seed)) % 4));
      row_w.push_back(elem_t'($random(seed)));
      for (int k = 0; k < LANES; k++)
        m[k] = elem_t'($random(seed));
      row_m.push_back(m);
    end
    for (int k = 0; k < LANES; k++)
      exp_r.push_back(column_sum(base, n, k));
  endtask

  task automatic run_job(input int jb, input int base);
    int                last_row;
    int                waited;
    elem_t [LANES-1:0] junk;
    en_cnt  = 0;
    rdy_cnt = 0;
    got.delete();
    // Stray strobes while idle are dropped by the DUT
    for (int s = 0; s < job_stray[jb]; s++) begin
      for (int k = 0; k < LANES; k++)
        junk[k] = elem_t'($random(seed));
      step_cycle(1'b0, 1'b1, '0, elem_t'($random(seed)), junk);
      idle_cycle();
    end
    check_count("R_OUT_ENABLE count before START", count_t'(en_cnt), '0);
    check_count("READY count before START", count_t'(rdy_cnt), '0);
    step_cycle(1'b1, 1'b0, job_n[jb], '0, '0);
    for (int j = 0; j < int'(job_n[jb]); j++) begin
      repeat (row_gap[base + j]) idle_cycle();
      step_cycle(1'b0, 1'b1, '0, row_w[base + j], row_m[base + j]);
    end
    last_row = cyc;
    // Burst runs on its own without back-pressure
    waited = 0;
    while (rdy_cnt == 0 && waited <= LANES + 10) begin
      idle_cycle();
      waited++;
    end
    if (rdy_cnt == 0) abort_run($sformatf("READY never came for job %0d", jb));
    // Two more cycles to catch extra pulses
    repeat (2) idle_cycle();
    check_count("R_OUT_ENABLE count", count_t'(en_cnt), count_t'(LANES));
    check_count("READY count", count_t'(rdy_cnt), count_t'(1));
    // Sampling edge plus 3 cycles as seen one falling edge later
    check_count("first R_OUT_ENABLE delay", count_t'(first_en - last_row), count_t'(4));
    // Words leave in consecutive cycles
    check_count("R_OUT_ENABLE burst length", count_t'(last_en - first_en + 1),
                count_t'(LANES));
    check_count("READY delay after last word", count_t'(ready_at - last_en), count_t'(1));
    for (int k = 0; k < LANES; k++)
      check_result(k, got[k], exp_r[jb * LANES + k]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run
  //////////////////////////////////////////////////////////////////////

  initial begin
    int base;
    START         = 1'b0;
    M_IN_J_ENABLE = 1'b0;
    SIZE_N_IN     = '0;
    W_IN          = '0;
    M_IN          = '0;
    load_stim();
    add_random_job();
    // 20 cycles a row, 50 a job, 2 per stray strobe, plus reset
    limit_cycles = 20 * row_w.size() + 50 * job_n.size() + 10;
    foreach (job_stray[i])
      limit_cycles += 2 * job_stray[i];
    @(negedge RST);
    repeat (4) idle_cycle();
    // Outputs quiet after reset
    check_count("R_OUT_ENABLE count after reset", count_t'(en_cnt), '0);
    check_count("READY count after reset", count_t'(rdy_cnt), '0);
    base = 0;
    for (int jb = 0; jb < job_n.size(); jb++) begin
      run_job(jb, base);
      base += int'(job_n[jb]);
    end
    $display("sim passed");
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge CLK);
    abort_run($sformatf("timeout after %0d cycles, the DUT stopped answering", limit_cycles));
  end

endmodule

/* tests/ntm_reading_stim.txt */
# job header: N stray_strobes (decimal); row: gap (decimal) weight M(j,0..3) (hex)
# expected line after the rows: r(0..3) in hex, 40-bit two's complement
1 2
0 FFFD 0005 FFF9 7FFF 8000
FFFFFFFFF1 0000000015 FFFFFE8003 0000018000
3 0
0 0002 0001 0002 0003 0004
0 FFFF 000A 0014 001E 0028
0 0003 FFFF 0000 0064 FFF6
FFFFFFFFF5 FFFFFFFFF0 0000000114 FFFFFFFFC2
3 1
3 0002 0001 0002 0003 0004
1 FFFF 000A 0014 001E 0028
5 0003 FFFF 0000 0064 FFF6
FFFFFFFFF5 FFFFFFFFF0 0000000114 FFFFFFFFC2
4 0
0 8000 8000 7FFF 0001 0000
2 8000 8000 7FFF 0001 0000
0 8000 8000 7FFF 0001 0000
1 8000 8000 7FFF 0001 0000
0100000000 FF00020000 FFFFFE0000 0000000000
2 0
1 0010 0100 FF00 0001 1234
0 FFF0 0100 0100 0002 0001
0000000000 FFFFFFE000 FFFFFFFFF0 0000012330

/* vlog.f */
design/ntm_pkg.sv
design/ntm_read_dispatch.sv
design/ntm_read_lane.sv
design/ntm_read_collect.sv
design/ntm_reading.sv
tests/tb_clock.sv
tests/tb_ntm_reading.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_ntm_reading \
	  -f vlog.f -Mdir obj_dir -o sim
	./obj_dir/sim 2>&1 | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAILED"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "FAILED"; exit 1; }
	@echo "PASSED"

clean:
	rm -rf obj_dir $(LOG)
